// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= uart_link.f
TB_TOP    ?= uart_link_tb
RTL_TOP   ?= uart_link
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: common/uart_pkg.sv
package uart_pkg;

    // serial timing, kept short so simulation runs fast.
    localparam int bit_period  = 16;
    localparam int half_period = bit_period / 2;
    localparam int baud_cnt_w  = $clog2(bit_period);

    // transmit queue.
    localparam int fifo_depth  = 8;
    localparam int fifo_addr_w = 3;

    // 8N1 frame.
    localparam int data_bits   = 8;
    localparam int bit_idx_w   = $clog2(data_bits);

endpackage

// File: hdl/baud_rate_gen.sv
`timescale 1ns/100ps

module baud_rate_gen
    import uart_pkg::*;
(
    input  logic clk,
    input  logic reset,
    output logic baud_tick
);

    logic [baud_cnt_w-1:0] baud_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            baud_cnt  <= '0;
            baud_tick <= 1'b0;
        end else begin
            if (baud_cnt == baud_cnt_w'(bit_period - 1)) begin
                baud_cnt  <= '0;
                baud_tick <= 1'b1; // one pulse per bit period.
            end else begin
                baud_cnt  <= baud_cnt + 1'b1;
                baud_tick <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/byte_fifo.sv
`timescale 1ns/100ps

module byte_fifo
    import uart_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [data_bits-1:0] wr_data,
    input  logic                 write,
    input  logic                 pop,
    output logic [data_bits-1:0] head_data,
    output logic                 full,
    output logic                 empty
);

    logic [data_bits-1:0]   mem [fifo_depth];
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    logic [fifo_addr_w:0]   count;
    logic [fifo_addr_w:0]   count_next;
    logic                   do_write;
    logic                   do_pop;

    assign do_write = write && !full; // writes into a full queue are lost.
    assign do_pop   = pop && !empty;

    always_comb begin
        case ({do_write, do_pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count; // both or neither.
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            full  <= (count_next == (fifo_addr_w + 1)'(fifo_depth)); // levels track count after the edge.
            empty <= (count_next == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign head_data = mem[rd_ptr]; // oldest byte, always presented.

    // the transmitter may only pop what the queue reports as present
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset) pop |-> !empty
    ) else $error("byte_fifo: pop while empty");

    a_full_empty_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(full && empty)
    ) else $error("byte_fifo: full and empty together");

endmodule

// File: hdl/uart_link.sv
`timescale 1ns/100ps

module uart_link
    import uart_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [data_bits-1:0] tx_data,
    input  logic                 tx_write,
    output logic                 tx_full,
    output logic                 busy,
    output logic                 tx_out,
    input  logic                 rx_in,
    output logic [data_bits-1:0] rx_data,
    output logic                 rx_valid,
    output logic                 rx_frame_error
);

    logic                 baud_tick;
    logic [data_bits-1:0] head_data;
    logic                 fifo_empty;
    logic                 pop;

    byte_fifo i_byte_fifo (
        .clk       (clk),
        .reset     (reset),
        .wr_data   (tx_data),
        .write     (tx_write),
        .pop       (pop),
        .head_data (head_data),
        .full      (tx_full),
        .empty     (fifo_empty)
    );

    baud_rate_gen i_baud_rate_gen (
        .clk       (clk),
        .reset     (reset),
        .baud_tick (baud_tick)
    );

    uart_tx i_uart_tx (
        .clk       (clk),
        .reset     (reset),
        .baud_tick (baud_tick),
        .head_data (head_data),
        .empty     (fifo_empty),
        .pop       (pop),
        .tx_out    (tx_out),
        .busy      (busy)
    );

    // receiver runs on its own sample counter, not on baud_tick.
    uart_rx i_uart_rx (
        .clk            (clk),
        .reset          (reset),
        .rx_in          (rx_in),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_frame_error (rx_frame_error)
    );

endmodule

// File: uart_link.f
common/uart_pkg.sv
hdl/baud_rate_gen.sv
hdl/byte_fifo.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
hdl/uart_link.sv
verif/uart_link_tb.sv

// File: uart_rx/uart_rx.sv
`timescale 1ns/100ps

module uart_rx
    import uart_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rx_in,
    output logic [data_bits-1:0] rx_data,
    output logic                 rx_valid,
    output logic                 rx_frame_error
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_t;

    rx_state_t             state;
    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_prev;
    logic [baud_cnt_w-1:0] sample_cnt;
    logic [bit_idx_w-1:0]  bit_idx;
    logic [data_bits-1:0]  shift_reg;
    logic                  bit_end;
    logic                  half_end;

    // async line into the clock domain
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_in;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign bit_end  = (sample_cnt == baud_cnt_w'(bit_period - 1));
    assign half_end = (sample_cnt == baud_cnt_w'(half_period - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= IDLE;
            sample_cnt     <= '0;
            bit_idx        <= '0;
            rx_valid       <= 1'b0;
            rx_frame_error <= 1'b0;
        end else begin
            rx_valid       <= 1'b0;
            rx_frame_error <= 1'b0;
            sample_cnt     <= sample_cnt + 1'b1;
            case (state)
                IDLE: begin
                    sample_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= START; // falling edge.
                    end
                end

                START: begin
                    if (half_end) begin
                        sample_cnt <= '0;
                        bit_idx    <= '0;
                        state      <= rx_sync ? IDLE : DATA; // high here is a glitch.
                    end
                end

                DATA: begin
                    if (bit_end) begin
                        sample_cnt <= '0;
                        if (bit_idx == bit_idx_w'(data_bits - 1)) begin
                            state <= STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end

                STOP: begin
                    if (bit_end) begin
                        sample_cnt     <= '0;
                        state          <= IDLE;
                        rx_valid       <= rx_sync;
                        rx_frame_error <= !rx_sync; // stop bit must be high.
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA && bit_end) begin
            shift_reg <= {rx_sync, shift_reg[data_bits-1:1]}; // lsb arrives first.
        end
        if (state == STOP && bit_end) begin
            rx_data <= shift_reg;
        end
    end

    a_valid_xor_error: assert property (
        @(posedge clk) disable iff (reset) !(rx_valid && rx_frame_error)
    ) else $error("uart_rx: valid and frame error together");

endmodule

// File: uart_tx/uart_tx.sv
`timescale 1ns/100ps

module uart_tx
    import uart_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 baud_tick,
    input  logic [data_bits-1:0] head_data,
    input  logic                 empty,
    output logic                 pop,
    output logic                 tx_out,
    output logic                 busy
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_t;

    tx_state_t            state;
    logic [bit_idx_w-1:0] bit_cnt;
    logic [data_bits-1:0] shift_buf;

    // take the head byte only on a tick while idle.
    assign pop = baud_tick && (state == IDLE) && !empty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            bit_cnt <= '0;
            tx_out  <= 1'b1;
            busy    <= 1'b0;
        end else if (baud_tick) begin
            case (state)
                IDLE: begin
                    if (!empty) begin
                        state  <= START;
                        tx_out <= 1'b0; // start bit.
                        busy   <= 1'b1;
                    end
                end

                START: begin
                    state   <= DATA;
                    bit_cnt <= '0;
                    tx_out  <= shift_buf[0]; // lsb first.
                end

                DATA: begin
                    if (bit_cnt == bit_idx_w'(data_bits - 1)) begin
                        state  <= STOP;
                        tx_out <= 1'b1; // stop bit.
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        tx_out  <= shift_buf[0];
                    end
                end

                STOP: begin
                    state <= IDLE;
                    busy  <= 1'b0;
                end

                default: begin
                    state  <= IDLE;
                    tx_out <= 1'b1;
                    busy   <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shift_buf <= head_data;
        end else if (baud_tick && (state == START || state == DATA)) begin
            shift_buf <= shift_buf >> 1; // next bit moves to position 0.
        end
    end

    a_low_line_is_busy: assert property (
        @(posedge clk) disable iff (reset) !tx_out |-> busy
    ) else $error("uart_tx: line low outside a frame");

endmodule

// File: verif/uart_link_tb.sv
`timescale 1ns/100ps

module uart_link_tb
    import uart_pkg::*;
();

    logic                 clk;
    logic                 reset;
    logic [data_bits-1:0] tx_data;
    logic                 tx_write;
    logic                 tx_full;
    logic                 busy;
    logic                 tx_out;
    logic                 rx_in;
    logic [data_bits-1:0] rx_data;
    logic                 rx_valid;
    logic                 rx_frame_error;
    logic                 loopback;
    logic                 drv_line;

    logic [data_bits-1:0] rx_queue[$];
    logic                 busy_at_rx[$];
    int                   ferr_count;
    int                   checks;
    int                   mismatches;
    int                   timeouts;

    assign rx_in = loopback ? tx_out : drv_line; // serial driver when loopback is off.

    uart_link i_uart_link (.*);

    always #5 clk = ~clk;

    // receiver monitor, samples away from the rising edge.
    always @(negedge clk) begin
        if (!reset) begin
            if (rx_valid) begin
                rx_queue.push_back(rx_data);
                busy_at_rx.push_back(busy);
            end
            if (rx_frame_error) begin
                ferr_count++;
            end
        end
    end

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            mismatches++;
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string name, input string what);
        timeouts++;
        $display("timeout in %s: %s did not happen in time", name, what);
    endtask

    task automatic write_byte(input logic [data_bits-1:0] value);
        @(posedge clk);
        tx_data  <= value;
        tx_write <= 1'b1;
        @(posedge clk);
        tx_write <= 1'b0;
    endtask

    task automatic wait_line_low(input string name, output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < 3 * bit_period) begin
            @(negedge clk);
            cycles++;
            found = (tx_out == 1'b0);
        end
        if (!found) begin
            report_timeout(name, "start bit on tx_out");
        end
    endtask

    task automatic wait_busy(input string name, input logic level, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy !== level && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (busy !== level) begin
            report_timeout(name, level ? "busy rising" : "busy falling");
        end
    endtask

    task automatic wait_rx_events(input string name, input int bytes, input int errors,
                                  input int limit);
        int cycles;
        cycles = 0;
        while ((rx_queue.size() < bytes || ferr_count < errors) && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (rx_queue.size() < bytes || ferr_count < errors) begin
            report_timeout(name, "receiver output");
        end
    endtask

    task automatic send_serial_frame(input logic [data_bits-1:0] value, input logic stop_level);
        logic [data_bits+1:0] frame;
        int                   i;
        frame = {stop_level, value, 1'b0};
        for (i = 0; i < data_bits + 2; i++) begin
            @(posedge clk);
            drv_line <= frame[i];
            repeat (bit_period - 1) @(posedge clk);
        end
        @(posedge clk);
        drv_line <= 1'b1; // idle gap.
        repeat (2 * bit_period) @(posedge clk);
    endtask

    task automatic reset_state_test();
        @(negedge clk);
        compare_values("reset tx_out", 1, 32'(tx_out));
        compare_values("reset busy", 0, 32'(busy));
        compare_values("reset tx_full", 0, 32'(tx_full));
        compare_values("reset rx_valid", 0, 32'(rx_valid));
        compare_values("reset rx_frame_error", 0, 32'(rx_frame_error));
    endtask

    task automatic frame_shape_test();
        logic [data_bits-1:0] value;
        bit                   found;
        int                   i;
        value = data_bits'($urandom);
        write_byte(value);
        wait_line_low("frame_shape", found);
        if (found) begin
            repeat (half_period) @(negedge clk); // middle of the start bit.
            compare_values("frame_shape start", 0, 32'(tx_out));
            for (i = 0; i < data_bits; i++) begin
                repeat (bit_period) @(negedge clk);
                compare_values("frame_shape data", 32'(value[i]), 32'(tx_out));
            end
            repeat (bit_period) @(negedge clk);
            compare_values("frame_shape stop", 1, 32'(tx_out));
        end
        wait_busy("frame_shape", 1'b0, 4 * bit_period);
    endtask

    task automatic loopback_byte_test();
        logic [data_bits-1:0] value;
        int                   base;
        value = data_bits'($urandom);
        base  = ferr_count;
        @(posedge clk);
        loopback <= 1'b1;
        rx_queue.delete();
        busy_at_rx.delete();
        write_byte(value);
        wait_rx_events("loopback_byte", 1, base, 14 * bit_period);
        wait_busy("loopback_byte", 1'b0, 4 * bit_period);
        repeat (2 * bit_period) @(posedge clk);
        compare_values("loopback_byte count", 1, rx_queue.size());
        if (rx_queue.size() > 0) begin
            compare_values("loopback_byte data", 32'(value), 32'(rx_queue[0]));
        end
        compare_values("loopback_byte frame errors", base, ferr_count);
    endtask

    task automatic burst_test();
        logic [data_bits-1:0] value;
        logic [data_bits-1:0] accepted[$];
        int                   i;
        rx_queue.delete();
        busy_at_rx.delete();
        for (i = 0; i < fifo_depth + 2; i++) begin
            value = data_bits'($urandom);
            @(posedge clk);
            tx_data  <= value;
            tx_write <= 1'b1;
            @(negedge clk);
            if (!tx_full) begin
                accepted.push_back(value); // full here blocks the write at the next edge.
            end
        end
        @(posedge clk);
        tx_write <= 1'b0;
        compare_values("burst dropped", 1, 32'(accepted.size() < fifo_depth + 2));
        wait_busy("burst", 1'b1, 2 * bit_period);
        wait_rx_events("burst", accepted.size(), 0, (accepted.size() + 2) * 12 * bit_period);
        wait_busy("burst", 1'b0, 4 * bit_period);
        repeat (12 * bit_period) @(negedge clk); // room for a stray frame.
        compare_values("burst count", accepted.size(), rx_queue.size());
        for (i = 0; i < accepted.size() && i < rx_queue.size(); i++) begin
            compare_values("burst data", 32'(accepted[i]), 32'(rx_queue[i]));
            compare_values("burst busy", 1, 32'(busy_at_rx[i]));
        end
        compare_values("burst busy after", 0, 32'(busy));
    endtask

    task automatic frame_error_test();
        logic [data_bits-1:0] value;
        int                   base;
        base = ferr_count;
        @(posedge clk);
        loopback <= 1'b0;
        rx_queue.delete();
        busy_at_rx.delete();
        send_serial_frame(data_bits'($urandom), 1'b0);
        wait_rx_events("frame_error", 0, base + 1, 2 * bit_period);
        compare_values("frame_error pulses", base + 1, ferr_count);
        compare_values("frame_error valid", 0, rx_queue.size());
        value = data_bits'($urandom);
        send_serial_frame(value, 1'b1);
        wait_rx_events("frame_error good", 1, base + 1, 2 * bit_period);
        compare_values("frame_error good count", 1, rx_queue.size());
        if (rx_queue.size() > 0) begin
            compare_values("frame_error good data", 32'(value), 32'(rx_queue[0]));
        end
        compare_values("frame_error good errors", base + 1, ferr_count);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        tx_data    = '0;
        tx_write   = 1'b0;
        loopback   = 1'b0;
        drv_line   = 1'b1;
        ferr_count = 0;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        void'($urandom(32'h623da5ac));
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        reset_state_test();
        frame_shape_test();
        loopback_byte_test();
        burst_test();
        frame_error_test();
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
